// File: rtl/counter_bus_pkg.sv
// Bus types, register offsets and bin memory address map of the pulse counter

package counter_bus_pkg;

   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;

   // Register offsets inside region 0
   localparam bus_addr_t REG_CMD_STATE = 32'h00;  // W command, R state code
   localparam bus_addr_t REG_TIMEOUT   = 32'h04;
   localparam bus_addr_t REG_LAST_CH1  = 32'h08;
   localparam bus_addr_t REG_LAST_CH2  = 32'h0C;
   localparam bus_addr_t REG_BINS      = 32'h10;
   localparam bus_addr_t REG_REPS      = 32'h14;
   localparam bus_addr_t REG_PREDELAY  = 32'h18;
   localparam bus_addr_t REG_TRIG_CFG  = 32'h1C;  // Mask, inversion, polarity
   localparam bus_addr_t REG_BIN_INDEX = 32'h20;
   localparam bus_addr_t REG_REP_INDEX = 32'h24;

   // Region field at address bits 19:16
   localparam int BUS_REGION_LSB  = 16;
   localparam int BUS_REGION_W    = 4;
   localparam int BUS_REGION_REGS = 0;
   localparam int BUS_REGION_RAM  = 1;

   // Bin memory window inside region 1
   localparam int RAM_HOLE_BIT   = 15;  // Set means unmapped
   localparam int RAM_CH_SEL_BIT = 14;
   localparam int RAM_WORD_LSB   = 2;

endpackage

// File: rtl/counter_pkg.sv
// Counter widths, command and state encodings and reset defaults

package counter_pkg;

   localparam int NUM_CHANNELS = 2;
   localparam int NUM_INPUTS   = 4;

   typedef logic [31:0] count_t;      // Counts and cycle values
   typedef logic [11:0] bin_addr_t;
   typedef logic [17:0] bin_data_t;
   typedef logic [15:0] rep_t;
   typedef logic [7:0]  trig_mask_t;

   // Bus codes of the commands, code 5 is unused
   typedef enum logic [2:0] {
      cmd_none            = 3'd0,
      cmd_goto_idle       = 3'd1,
      cmd_reset_bins      = 3'd2,
      cmd_count_immediate = 3'd3,
      cmd_count_triggered = 3'd4,
      cmd_trigger         = 3'd6
   } command_e;

   // Values equal the state codes seen on readback
   typedef enum logic [2:0] {
      st_idle              = 3'd0,
      st_imm_start         = 3'd1,
      st_imm_wait_timeout  = 3'd2,
      st_trig_wait_trigger = 3'd3,
      st_trig_store        = 3'd4,
      st_trig_predelay     = 3'd5,
      st_trig_prestore     = 3'd6,
      st_trig_wait_timeout = 3'd7
   } seq_state_e;

   localparam count_t DEFAULT_TIMEOUT = 32'd125;  // 1 us at 125 MHz
   localparam int     BIN_DEPTH       = 4096;

endpackage

// File: rtl/edge_counter.sv
// Rising edge counter for one input, cleared while disabled
`timescale 1ns/1ps

module edge_counter
   import counter_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_rstn,
   input  logic   i_signal,
   input  logic   i_enable,
   output count_t o_count
);

   logic sig_q;  // Input one cycle earlier

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         sig_q   <= 1'b0;
         o_count <= '0;
      end else begin
         sig_q <= i_signal;
         if (!i_enable) begin
            o_count <= '0;
         end else if (i_signal && !sig_q) begin
            o_count <= o_count + 1'b1;
         end
      end
   end

endmodule

// File: rtl/bin_ram.sv
// True dual-port bin memory, read-before-write on both ports
`timescale 1ns/1ps

module bin_ram #(
   parameter int ADDR_W = 12,
   parameter int DATA_W = 18,
   parameter int DEPTH  = 4096
) (
   input  logic              i_clk,
   // Port a, accumulation
   input  logic [ADDR_W-1:0] i_addr_a,
   input  logic              i_we_a,
   input  logic [DATA_W-1:0] i_data_a,
   output logic [DATA_W-1:0] o_data_a,
   // Port b, software access
   input  logic [ADDR_W-1:0] i_addr_b,
   input  logic              i_we_b,
   input  logic [DATA_W-1:0] i_data_b,
   output logic [DATA_W-1:0] o_data_b
);

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge i_clk) begin
      o_data_a <= mem[i_addr_a];  // Old word when written in the same cycle
      o_data_b <= mem[i_addr_b];
      if (i_we_a) begin
         mem[i_addr_a] <= i_data_a;
      end
      if (i_we_b) begin
         mem[i_addr_b] <= i_data_b;
      end
   end

endmodule

// File: rtl/count_sequencer.sv
// Count window FSM with predelay, trigger detection and bin accumulation
`timescale 1ns/1ps

module count_sequencer
   import counter_pkg::*;
(
   input  logic                         i_clk,
   input  logic                         i_rstn,
   input  logic [NUM_INPUTS-1:0]        i_inputs,
   input  command_e                     i_cmd,
   input  logic                         i_cmd_valid,
   input  count_t                       i_timeout,
   input  count_t                       i_predelay,
   input  bin_addr_t                    i_bins_in_use,
   input  rep_t                         i_repetitions,
   input  trig_mask_t                   i_trig_mask,
   input  trig_mask_t                   i_trig_invert,
   input  logic                         i_trig_polarity,
   input  count_t    [NUM_CHANNELS-1:0] i_counts,
   output logic                         o_count_enable,
   input  bin_data_t [NUM_CHANNELS-1:0] i_ram_rdata,
   output bin_addr_t                    o_ram_addr,
   output bin_data_t [NUM_CHANNELS-1:0] o_ram_wdata,
   output logic                         o_ram_we,
   output seq_state_e                   o_state,
   output count_t    [NUM_CHANNELS-1:0] o_last_count,
   output bin_addr_t                    o_bin_index,
   output rep_t                         o_rep_index
);

   count_t timer;     // Predelay and timeout down counter
   logic   trig_sig;
   logic   trig_q;
   logic   trig_start;
   logic   mode_cmd;  // Command that changes the mode

   // Any masked, inverted input set, compared against the polarity
   assign trig_sig = (|((trig_mask_t'(i_inputs) ^ i_trig_invert) & i_trig_mask))
                     == i_trig_polarity;
   assign trig_start = (trig_sig && !trig_q) || (i_cmd_valid && i_cmd == cmd_trigger);
   assign mode_cmd = i_cmd_valid && i_cmd != cmd_none && i_cmd != cmd_trigger;

   assign o_ram_addr = o_bin_index;  // Counting port follows the current bin

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_state        <= st_idle;
         timer          <= '0;
         trig_q         <= 1'b0;
         o_count_enable <= 1'b0;
         o_ram_we       <= 1'b0;
         o_last_count   <= '0;
         o_bin_index    <= '0;
         o_rep_index    <= '0;
      end else begin
         trig_q <= trig_sig;
         if (mode_cmd) begin
            o_count_enable <= 1'b0;
            o_ram_we       <= 1'b0;
            case (i_cmd)
               cmd_count_immediate: o_state <= st_imm_start;
               cmd_count_triggered: o_state <= st_trig_wait_trigger;
               cmd_reset_bins: begin
                  o_bin_index  <= '0;
                  o_rep_index  <= '0;
                  o_last_count <= '0;
                  o_state      <= st_idle;
               end
               default: o_state <= st_idle;  // goto_idle
            endcase
         end else begin
            case (o_state)
               st_imm_start: begin
                  timer          <= i_timeout;
                  o_count_enable <= 1'b1;
                  o_state        <= st_imm_wait_timeout;
               end
               st_imm_wait_timeout, st_trig_wait_timeout: begin
                  if (timer == '0) begin
                     o_count_enable <= 1'b0;
                     o_last_count   <= i_counts;
                     o_state <= (o_state == st_imm_wait_timeout) ? st_idle : st_trig_prestore;
                  end else begin
                     timer <= timer - 1'b1;
                  end
               end
               st_trig_wait_trigger: begin
                  if (trig_start) begin
                     if (i_predelay != '0) begin
                        timer   <= i_predelay - 1'b1;
                        o_state <= st_trig_predelay;
                     end else begin
                        timer          <= i_timeout;
                        o_count_enable <= 1'b1;
                        o_state        <= st_trig_wait_timeout;
                     end
                  end
               end
               st_trig_predelay: begin
                  if (timer == '0) begin
                     timer          <= i_timeout;
                     o_count_enable <= 1'b1;
                     o_state        <= st_trig_wait_timeout;
                  end else begin
                     timer <= timer - 1'b1;
                  end
               end
               st_trig_prestore: begin
                  o_ram_we <= 1'b1;  // Sum lands at the end of store
                  o_state  <= st_trig_store;
               end
               st_trig_store: begin
                  o_ram_we <= 1'b0;
                  if (o_rep_index == i_repetitions) begin
                     o_rep_index <= '0;
                     // bins_in_use of 0 wraps after 4095
                     if (o_bin_index == bin_addr_t'(i_bins_in_use - 1'b1)) begin
                        o_bin_index <= '0;
                     end else begin
                        o_bin_index <= o_bin_index + 1'b1;
                     end
                  end else begin
                     o_rep_index <= o_rep_index + 1'b1;
                  end
                  o_state <= st_trig_wait_trigger;
               end
               default: begin
                  o_count_enable <= 1'b0;
                  o_ram_we       <= 1'b0;
               end
            endcase
         end
      end
   end

   // Old bin contents plus the low bits of the last window
   always_ff @(posedge i_clk) begin
      if (o_state == st_trig_prestore) begin
         for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            o_ram_wdata[ch] <= i_ram_rdata[ch] + o_last_count[ch][$bits(bin_data_t)-1:0];
         end
      end
   end

endmodule

// File: rtl/counter_regs.sv
// Bus register file, command strobes, readback mux and software bin memory port
`timescale 1ns/1ps

module counter_regs
   import counter_bus_pkg::*;
   import counter_pkg::*;
(
   input  logic                         i_clk,
   input  logic                         i_rstn,
   input  bus_addr_t                    i_sys_addr,
   input  bus_data_t                    i_sys_wdata,
   input  logic                         i_sys_wen,
   input  logic                         i_sys_ren,
   output bus_data_t                    o_sys_rdata,
   output logic                         o_sys_ack,
   output command_e                     o_cmd,
   output logic                         o_cmd_valid,
   output count_t                       o_timeout,
   output count_t                       o_predelay,
   output bin_addr_t                    o_bins_in_use,
   output rep_t                         o_repetitions,
   output trig_mask_t                   o_trig_mask,
   output trig_mask_t                   o_trig_invert,
   output logic                         o_trig_polarity,
   input  seq_state_e                   i_state,
   input  count_t    [NUM_CHANNELS-1:0] i_last_count,
   input  bin_addr_t                    i_bin_index,
   input  rep_t                         i_rep_index,
   output bin_addr_t                    o_ram_addr,
   output bin_data_t                    o_ram_wdata,
   output logic      [NUM_CHANNELS-1:0] o_ram_we,
   input  bin_data_t [NUM_CHANNELS-1:0] i_ram_rdata
);

   logic [BUS_REGION_W-1:0]   region;
   logic [BUS_REGION_LSB-1:0] reg_off;
   logic                      is_reg;
   logic                      is_ram;
   logic                      ram_ch;
   logic                      rd_pending;  // Bin memory read in flight
   logic                      rd_ch;
   command_e                  cmd_dec;
   bus_data_t                 reg_rdata;

   assign region  = i_sys_addr[BUS_REGION_LSB +: BUS_REGION_W];
   assign reg_off = i_sys_addr[BUS_REGION_LSB-1:0];
   assign is_reg  = region == BUS_REGION_W'(BUS_REGION_REGS);
   assign is_ram  = region == BUS_REGION_W'(BUS_REGION_RAM) && !i_sys_addr[RAM_HOLE_BIT];
   assign ram_ch  = i_sys_addr[RAM_CH_SEL_BIT];

   // Software port sees the bus directly so writes land on the wen edge
   assign o_ram_addr  = i_sys_addr[RAM_WORD_LSB +: $bits(bin_addr_t)];
   assign o_ram_wdata = i_sys_wdata[$bits(bin_data_t)-1:0];
   always_comb begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
         o_ram_we[ch] = i_sys_wen && is_ram && (ram_ch == ch[0]);
      end
   end

   always_comb begin
      case (i_sys_wdata)
         32'd1:   cmd_dec = cmd_goto_idle;
         32'd2:   cmd_dec = cmd_reset_bins;
         32'd3:   cmd_dec = cmd_count_immediate;
         32'd4:   cmd_dec = cmd_count_triggered;
         32'd6:   cmd_dec = cmd_trigger;
         default: cmd_dec = cmd_none;  // Code 5 and all unused codes
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_cmd           <= cmd_none;
         o_cmd_valid     <= 1'b0;
         o_timeout       <= DEFAULT_TIMEOUT;
         o_predelay      <= '0;
         o_bins_in_use   <= '0;
         o_repetitions   <= '0;
         o_trig_mask     <= '0;
         o_trig_invert   <= '0;
         o_trig_polarity <= 1'b0;
      end else begin
         o_cmd_valid <= 1'b0;
         if (i_sys_wen && is_reg) begin
            case (bus_addr_t'(reg_off))
               REG_CMD_STATE: begin
                  o_cmd       <= cmd_dec;
                  o_cmd_valid <= 1'b1;
               end
               REG_TIMEOUT:  o_timeout     <= i_sys_wdata;
               REG_BINS:     o_bins_in_use <= i_sys_wdata[$bits(bin_addr_t)-1:0];
               REG_REPS:     o_repetitions <= i_sys_wdata[$bits(rep_t)-1:0];
               REG_PREDELAY: o_predelay    <= i_sys_wdata;
               REG_TRIG_CFG: begin
                  o_trig_mask     <= i_sys_wdata[7:0];
                  o_trig_invert   <= i_sys_wdata[15:8];
                  o_trig_polarity <= i_sys_wdata[16];
               end
               default: ;  // Read-only or unmapped
            endcase
         end
      end
   end

   always_comb begin
      reg_rdata = '0;
      if (is_reg) begin
         case (bus_addr_t'(reg_off))
            REG_CMD_STATE: reg_rdata = bus_data_t'(i_state);
            REG_TIMEOUT:   reg_rdata = o_timeout;
            REG_LAST_CH1:  reg_rdata = i_last_count[0];
            REG_LAST_CH2:  reg_rdata = i_last_count[1];
            REG_BINS:      reg_rdata = bus_data_t'(o_bins_in_use);
            REG_REPS:      reg_rdata = bus_data_t'(o_repetitions);
            REG_PREDELAY:  reg_rdata = o_predelay;
            REG_TRIG_CFG:  reg_rdata = {15'b0, o_trig_polarity, o_trig_invert, o_trig_mask};
            REG_BIN_INDEX: reg_rdata = bus_data_t'(i_bin_index);
            REG_REP_INDEX: reg_rdata = bus_data_t'(i_rep_index);
            default:       reg_rdata = '0;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_sys_ack  <= 1'b0;
         rd_pending <= 1'b0;
         rd_ch      <= 1'b0;
      end else begin
         rd_pending <= i_sys_ren && is_ram;
         rd_ch      <= ram_ch;
         // Memory reads ack one cycle later than register reads
         o_sys_ack  <= rd_pending || i_sys_wen || (i_sys_ren && !is_ram);
      end
   end

   always_ff @(posedge i_clk) begin
      if (rd_pending) begin
         o_sys_rdata <= bus_data_t'(i_ram_rdata[rd_ch]);
      end else begin
         o_sys_rdata <= reg_rdata;
      end
   end

endmodule

// File: rtl/red_pitaya_counter.sv
// Two-channel pulse counter top with register file, sequencer, counters and bin memories
`timescale 1ns/1ps

module red_pitaya_counter
   import counter_bus_pkg::*;
   import counter_pkg::*;
(
   input  logic                  i_clk,
   input  logic                  i_rstn,
   input  logic [NUM_INPUTS-1:0] i_inputs,
   input  bus_addr_t             i_sys_addr,
   input  bus_data_t             i_sys_wdata,
   input  logic                  i_sys_wen,
   input  logic                  i_sys_ren,
   output bus_data_t             o_sys_rdata,
   output logic                  o_sys_ack
);

   command_e   cmd;
   logic       cmd_valid;
   count_t     timeout;
   count_t     predelay;
   bin_addr_t  bins_in_use;
   rep_t       repetitions;
   trig_mask_t trig_mask;
   trig_mask_t trig_invert;
   logic       trig_polarity;
   seq_state_e state;
   bin_addr_t  bin_index;
   rep_t       rep_index;
   logic       count_enable;

   count_t    [NUM_CHANNELS-1:0] counts;
   count_t    [NUM_CHANNELS-1:0] last_count;
   // Counting port of the memories
   bin_addr_t                    cnt_ram_addr;
   logic                         cnt_ram_we;
   bin_data_t [NUM_CHANNELS-1:0] cnt_ram_wdata;
   bin_data_t [NUM_CHANNELS-1:0] cnt_ram_rdata;
   // Software port of the memories
   bin_addr_t                    sw_ram_addr;
   bin_data_t                    sw_ram_wdata;
   logic      [NUM_CHANNELS-1:0] sw_ram_we;
   bin_data_t [NUM_CHANNELS-1:0] sw_ram_rdata;

   counter_regs u_regs (
      .i_clk           (i_clk),
      .i_rstn          (i_rstn),
      .i_sys_addr      (i_sys_addr),
      .i_sys_wdata     (i_sys_wdata),
      .i_sys_wen       (i_sys_wen),
      .i_sys_ren       (i_sys_ren),
      .o_sys_rdata     (o_sys_rdata),
      .o_sys_ack       (o_sys_ack),
      .o_cmd           (cmd),
      .o_cmd_valid     (cmd_valid),
      .o_timeout       (timeout),
      .o_predelay      (predelay),
      .o_bins_in_use   (bins_in_use),
      .o_repetitions   (repetitions),
      .o_trig_mask     (trig_mask),
      .o_trig_invert   (trig_invert),
      .o_trig_polarity (trig_polarity),
      .i_state         (state),
      .i_last_count    (last_count),
      .i_bin_index     (bin_index),
      .i_rep_index     (rep_index),
      .o_ram_addr      (sw_ram_addr),
      .o_ram_wdata     (sw_ram_wdata),
      .o_ram_we        (sw_ram_we),
      .i_ram_rdata     (sw_ram_rdata)
   );

   count_sequencer u_seq (
      .i_clk           (i_clk),
      .i_rstn          (i_rstn),
      .i_inputs        (i_inputs),
      .i_cmd           (cmd),
      .i_cmd_valid     (cmd_valid),
      .i_timeout       (timeout),
      .i_predelay      (predelay),
      .i_bins_in_use   (bins_in_use),
      .i_repetitions   (repetitions),
      .i_trig_mask     (trig_mask),
      .i_trig_invert   (trig_invert),
      .i_trig_polarity (trig_polarity),
      .i_counts        (counts),
      .o_count_enable  (count_enable),
      .i_ram_rdata     (cnt_ram_rdata),
      .o_ram_addr      (cnt_ram_addr),
      .o_ram_wdata     (cnt_ram_wdata),
      .o_ram_we        (cnt_ram_we),
      .o_state         (state),
      .o_last_count    (last_count),
      .o_bin_index     (bin_index),
      .o_rep_index     (rep_index)
   );

   // One counter and one bin memory per channel, channel n counts input n
   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
      edge_counter u_counter (
         .i_clk    (i_clk),
         .i_rstn   (i_rstn),
         .i_signal (i_inputs[ch]),
         .i_enable (count_enable),
         .o_count  (counts[ch])
      );

      bin_ram #(
         .ADDR_W ($bits(bin_addr_t)),
         .DATA_W ($bits(bin_data_t)),
         .DEPTH  (BIN_DEPTH)
      ) u_ram (
         .i_clk    (i_clk),
         .i_addr_a (cnt_ram_addr),
         .i_we_a   (cnt_ram_we),
         .i_data_a (cnt_ram_wdata[ch]),
         .o_data_a (cnt_ram_rdata[ch]),
         .i_addr_b (sw_ram_addr),
         .i_we_b   (sw_ram_we[ch]),
         .i_data_b (sw_ram_wdata),
         .o_data_b (sw_ram_rdata[ch])
      );
   end

endmodule

// File: include/tb_bus_tasks.svh
// Bus write and read tasks, pulse generator, state polling and value check for the testbench
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam int ACK_LIMIT = 16;  // Cycles to wait for o_sys_ack

task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
   assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
   end
endtask

// Polls the registered ack on falling edges
task automatic wait_for_ack();
   int cycles;
   cycles = 0;
   @(negedge clk);
   while (!sys_ack && cycles < ACK_LIMIT) begin
      @(negedge clk);
      cycles++;
   end
   assert (sys_ack) else begin
      errors++;
      $display("ERROR at %0t: bus access was never acknowledged", $time);
   end
endtask

task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
   @(posedge clk);
   sys_addr  <= addr;
   sys_wdata <= data;
   sys_wen   <= 1'b1;
   @(posedge clk);
   sys_wen <= 1'b0;
   wait_for_ack();
endtask

task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
   @(posedge clk);
   sys_addr <= addr;
   sys_ren  <= 1'b1;
   @(posedge clk);
   sys_ren <= 1'b0;
   wait_for_ack();
   data = sys_rdata;
endtask

task automatic read_check(input bus_addr_t addr, input string name, input bus_data_t exp);
   bus_data_t data;
   bus_read(addr, data);
   check_value(name, data, exp);
endtask

// Pulses of two cycles high and two low on inputs 0 and 1
task automatic drive_pulses(input int n1, input int n2);
   for (int i = 0; i < n1 || i < n2; i++) begin
      @(posedge clk);
      inputs[0] <= (i < n1);
      inputs[1] <= (i < n2);
      @(posedge clk);
      @(posedge clk);
      inputs[1:0] <= 2'b00;
      @(posedge clk);
   end
endtask

task automatic wait_for_state(input int code, input int polls);
   bus_data_t st;
   int        n;
   n = 0;
   bus_read(REG_CMD_STATE, st);
   while (st != bus_data_t'(code) && n < polls) begin
      bus_read(REG_CMD_STATE, st);
      n++;
   end
   assert (st == bus_data_t'(code)) else begin
      errors++;
      $display("ERROR at %0t: state code never reached %0d, last read %0d", $time, code, st);
   end
endtask

`endif

// File: test/tb_red_pitaya_counter.sv
// Testbench for the pulse counter with stimulus table, bin model, watchdog and summary
`timescale 1ns/1ps

module tb_red_pitaya_counter
   import counter_bus_pkg::*;
   import counter_pkg::*;
();

   localparam int NUM_ENTRIES    = 8;
   localparam int MODE_IMM       = 0;
   localparam int MODE_TRIG_IN2  = 1;  // Rising level on input 2
   localparam int MODE_TRIG_INV3 = 2;  // Falling level on input 3
   localparam int MODE_TRIG_SW   = 3;

   // Stimulus table with one column per entry
   int tbl_mode     [NUM_ENTRIES] = '{0, 0, 1, 1, 1, 2, 3, 3};
   int tbl_timeout  [NUM_ENTRIES] = '{150, 120, 150, 150, 150, 150, 150, 150};
   int tbl_predelay [NUM_ENTRIES] = '{0, 0, 10, 10, 10, 0, 20, 5};
   int tbl_reps     [NUM_ENTRIES] = '{0, 0, 2, 2, 2, 0, 0, 1};
   int tbl_bins     [NUM_ENTRIES] = '{0, 0, 0, 0, 0, 2, 2, 2};
   int tbl_maxp     [NUM_ENTRIES] = '{20, 18, 16, 16, 16, 16, 16, 16};
   int tbl_exp_bin  [NUM_ENTRIES] = '{0, 0, 0, 0, 1, 0, 1, 1};
   int tbl_exp_rep  [NUM_ENTRIES] = '{0, 0, 1, 2, 0, 0, 0, 1};

   logic                  clk;
   logic                  rstn;
   logic [NUM_INPUTS-1:0] inputs;
   bus_addr_t             sys_addr;
   bus_data_t             sys_wdata;
   logic                  sys_wen;
   logic                  sys_ren;
   bus_data_t             sys_rdata;
   logic                  sys_ack;
   int                    errors;
   int                    cur_bin;                    // Bin the next window lands in
   int                    bin_sum [NUM_CHANNELS][4];  // Expected bin contents

   `include "tb_bus_tasks.svh"

   always #2 clk = ~clk;

   red_pitaya_counter u_dut (
      .i_clk       (clk),
      .i_rstn      (rstn),
      .i_inputs    (inputs),
      .i_sys_addr  (sys_addr),
      .i_sys_wdata (sys_wdata),
      .i_sys_wen   (sys_wen),
      .i_sys_ren   (sys_ren),
      .o_sys_rdata (sys_rdata),
      .o_sys_ack   (sys_ack)
   );

   function automatic bus_addr_t ram_addr(input int ch, input int word);
      return 32'h0001_0000 | (bus_addr_t'(ch) << RAM_CH_SEL_BIT)
             | (bus_addr_t'(word) << RAM_WORD_LSB);
   endfunction

   function automatic bus_data_t trig_cfg_for(input int mode);
      case (mode)
         MODE_TRIG_IN2:                return 32'h0001_0004;  // Mask bit 2 with polarity 1
         MODE_TRIG_INV3, MODE_TRIG_SW: return 32'h0001_0808;  // Bit 3 masked and inverted
         default:                      return 32'h0;
      endcase
   endfunction

   task automatic run_entry(input int e);
      int mode;
      int n1;
      int n2;
      mode = tbl_mode[e];
      n1   = 1 + int'($urandom % tbl_maxp[e]);
      n2   = 1 + int'($urandom % tbl_maxp[e]);
      if (mode == MODE_TRIG_INV3) begin
         @(posedge clk);
         inputs[3] <= 1'b1;  // Idle level before the falling trigger
      end
      bus_write(REG_TIMEOUT, tbl_timeout[e]);
      bus_write(REG_PREDELAY, tbl_predelay[e]);
      bus_write(REG_REPS, tbl_reps[e]);
      bus_write(REG_BINS, tbl_bins[e]);
      bus_write(REG_TRIG_CFG, trig_cfg_for(mode));
      bus_write(REG_CMD_STATE, (mode == MODE_IMM) ? 32'd3 : 32'd4);
      case (mode)
         MODE_TRIG_IN2: begin
            @(posedge clk);
            inputs[2] <= 1'b1;
            repeat (3) @(posedge clk);
            inputs[2] <= 1'b0;
         end
         MODE_TRIG_INV3: begin
            @(posedge clk);
            inputs[3] <= 1'b0;
         end
         MODE_TRIG_SW: bus_write(REG_CMD_STATE, 32'd6);
         default: ;
      endcase
      repeat (tbl_predelay[e] + 8) @(posedge clk);  // Into the counting window
      drive_pulses(n1, n2);
      wait_for_state((mode == MODE_IMM) ? 0 : 3, 100);
      read_check(REG_LAST_CH1, "last_count ch1", n1);
      read_check(REG_LAST_CH2, "last_count ch2", n2);
      read_check(REG_BIN_INDEX, "bin_index", tbl_exp_bin[e]);
      read_check(REG_REP_INDEX, "rep_index", tbl_exp_rep[e]);
      if (mode != MODE_IMM) begin
         bin_sum[0][cur_bin] += n1;
         bin_sum[1][cur_bin] += n2;
         read_check(ram_addr(0, cur_bin), $sformatf("bin ch1[%0d]", cur_bin),
                    bin_sum[0][cur_bin] & 32'h3_FFFF);
         read_check(ram_addr(1, cur_bin), $sformatf("bin ch2[%0d]", cur_bin),
                    bin_sum[1][cur_bin] & 32'h3_FFFF);
         cur_bin = tbl_exp_bin[e];
      end
   endtask

   initial begin
      clk       = 1'b0;
      rstn      = 1'b0;
      inputs    = '0;
      sys_addr  = '0;
      sys_wdata = '0;
      sys_wen   = 1'b0;
      sys_ren   = 1'b0;
      errors    = 0;
      cur_bin   = 0;
      bin_sum   = '{default: 0};
      void'($urandom(32'haad5_2bf2));
      repeat (3) @(posedge clk);
      rstn <= 1'b1;

      read_check(REG_CMD_STATE, "state", 32'd0);
      read_check(REG_TIMEOUT, "timeout", 32'd125);
      read_check(REG_LAST_CH1, "last_count ch1", 32'd0);
      read_check(REG_LAST_CH2, "last_count ch2", 32'd0);
      read_check(REG_BIN_INDEX, "bin_index", 32'd0);
      read_check(REG_REP_INDEX, "rep_index", 32'd0);
      // Fields keep only their own width
      bus_write(REG_BINS, 32'hFFFF_F005);
      read_check(REG_BINS, "bins_in_use", 32'h0000_0005);
      bus_write(REG_REPS, 32'h1234_5678);
      read_check(REG_REPS, "repetitions", 32'h0000_5678);
      bus_write(REG_TRIG_CFG, 32'hFFFF_FFFF);
      read_check(REG_TRIG_CFG, "trig_cfg", 32'h0001_FFFF);
      bus_write(REG_PREDELAY, 32'hDEAD_BEEF);
      read_check(REG_PREDELAY, "predelay", 32'hDEAD_BEEF);
      bus_write(REG_TRIG_CFG, 32'h0);

      bus_write(ram_addr(1, 5), 32'hFFFA_BCDE);
      read_check(ram_addr(1, 5), "bin ch2[5]", 32'h0002_BCDE);
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
         for (int w = 0; w < 4; w++) begin
            bus_write(ram_addr(ch, w), 32'h0);
         end
      end

      for (int e = 0; e < NUM_ENTRIES; e++) begin
         run_entry(e);
      end

      bus_write(REG_CMD_STATE, 32'd2);
      read_check(REG_CMD_STATE, "state", 32'd0);
      read_check(REG_BIN_INDEX, "bin_index", 32'd0);
      read_check(REG_REP_INDEX, "rep_index", 32'd0);
      read_check(REG_LAST_CH1, "last_count ch1", 32'd0);
      read_check(REG_LAST_CH2, "last_count ch2", 32'd0);
      read_check(32'h0001_8000, "unmapped ram hole", 32'd0);
      read_check(32'h0002_0000, "unmapped region 2", 32'd0);
      read_check(32'h0000_0040, "unmapped register", 32'd0);

      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   initial begin : watchdog
      int limit;
      limit = 3000;
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         limit += tbl_timeout[e] + tbl_predelay[e] + 600;
      end
      repeat (limit) @(posedge clk);
      $display("ERROR: run did not finish within %0d cycles", limit);
      $display("Checks finished with %0d errors", errors + 1);
      $display("Verification failed");
      $finish;
   end

endmodule

// File: photon_counter.f
+incdir+include
rtl/counter_bus_pkg.sv
rtl/counter_pkg.sv
rtl/edge_counter.sv
rtl/bin_ram.sv
rtl/count_sequencer.sv
rtl/counter_regs.sv
rtl/red_pitaya_counter.sv
test/tb_red_pitaya_counter.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_red_pitaya_counter \
   -f photon_counter.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "Verification passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
